/* source/hostEmuPkg.sv */
/*
  shared constants and encodings for the host emulator
  record offsets count 32-bit beats from the start of a record
  the buffer holds the reduced frame only, header words included
*/
`default_nettype none

package hostEmuPkg;

  ////////////////////
  // sizes
  ////////////////////
  localparam int DataWidth       = 32;
  localparam int BufferDepth     = 128;
  localparam int BufferAddrWidth = $clog2(BufferDepth);
  localparam int CountWidth      = 10;   // beat and word counters

  ////////////////////
  // record layout
  ////////////////////
  localparam logic [CountWidth-1:0] HeaderWords      = 10'd4;  // also first record start
  localparam logic [CountWidth-1:0] CsrCountOffset   = 10'd9;  // low 16 bits hold the count
  localparam logic [CountWidth-1:0] RegEnableOffset  = 10'd10; // bit 8 gpr, bit 0 fpr
  localparam logic [CountWidth-1:0] BaseRecordLength = 10'd12;
  localparam logic [CountWidth-1:0] CsrExtraLength   = 10'd13;
  localparam logic [CountWidth-1:0] RegExtraLength   = 10'd2;

  // value put in record word 4 on the way back
  localparam logic [DataWidth-1:0] InterPacketDelay = 32'd1;

  // every (LossInterval+1)-th frame is dropped
  localparam logic [CountWidth-1:0] LossInterval = 10'd3;

  ////////////////////
  // encodings
  ////////////////////
  typedef enum logic [1:0] {opSkip, opKeep, opZero, opDelay} storeOp;

  typedef enum logic [1:0] {
    recvIdle,
    recvCapture,
    recvCaptureDone,
    recvDone
  } recvState;

  typedef enum logic [1:0] {sendReady, sendWait, sendTrans, sendFinished} sendState;

endpackage

`default_nettype wire

/* source/recordParser.sv */
/*
  decode stage: picks the store action for every input beat
  records must follow the header back to back, each one at least BaseRecordLength
  the inLast beat is a trailer and is never stored
  beats in the cycle right after inLast are ignored
*/
`timescale 1ns/100ps
`default_nettype none

module recordParser (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [hostEmuPkg::DataWidth-1:0] inData,
  input  logic                             inValid,
  input  logic                             inLast,
  output hostEmuPkg::storeOp               beatOp
);

  hostEmuPkg::recvState state;
  hostEmuPkg::recvState nextState;

  logic [hostEmuPkg::CountWidth-1:0] beatCount;    // beats seen in this frame
  logic [hostEmuPkg::CountWidth-1:0] recPtr;       // start beat of current record
  logic [hostEmuPkg::CountWidth-1:0] recOffset;
  logic [hostEmuPkg::CountWidth-1:0] recordLength;
  logic [15:0]                       csrCount;
  logic                              gprEnable;
  logic                              fprEnable;
  logic                              ptrAdvance;
  logic                              beatValid;
  logic                              frameClear;
  logic                              inHeader;

  ////////////////////
  // receive FSM
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) state <= hostEmuPkg::recvIdle;
    else state <= nextState;
  end

  always_comb begin
    nextState = state;
    case (state)
      hostEmuPkg::recvIdle, hostEmuPkg::recvDone: begin
        if (inValid && inLast) nextState = hostEmuPkg::recvCaptureDone;
        else if (inValid) nextState = hostEmuPkg::recvCapture;
        else nextState = hostEmuPkg::recvIdle;
      end
      hostEmuPkg::recvCapture: begin
        if (inValid && inLast) nextState = hostEmuPkg::recvCaptureDone;
      end
      hostEmuPkg::recvCaptureDone: nextState = hostEmuPkg::recvDone;
      default: nextState = hostEmuPkg::recvIdle;
    endcase
  end

  assign frameClear = state == hostEmuPkg::recvCaptureDone; // one cycle after inLast
  assign beatValid  = inValid && !frameClear;

  always_ff @(posedge clk) begin
    if (reset || frameClear) beatCount <= '0;
    else if (beatValid) beatCount <= beatCount + 1'b1;
  end

  ////////////////////
  // record tracking
  ////////////////////
  // wraps to a large value while still in the header, so no offset matches there
  assign recOffset = beatCount - recPtr;
  assign inHeader  = beatCount < hostEmuPkg::HeaderWords;

  always_ff @(posedge clk) begin
    if (beatValid && recOffset == hostEmuPkg::CsrCountOffset) csrCount <= inData[15:0];
    if (beatValid && recOffset == hostEmuPkg::RegEnableOffset) begin
      gprEnable <= inData[8];
      fprEnable <= inData[0];
    end
  end

  assign recordLength = hostEmuPkg::BaseRecordLength
                      + ((csrCount != 16'd0) ? hostEmuPkg::CsrExtraLength : '0)
                      + ((gprEnable || fprEnable) ? hostEmuPkg::RegExtraLength : '0);

  // pointer moves one cycle after the enable word, once both fields are latched
  always_ff @(posedge clk) begin
    if (reset || frameClear) ptrAdvance <= 1'b0;
    else ptrAdvance <= beatValid && recOffset == hostEmuPkg::RegEnableOffset;
  end

  always_ff @(posedge clk) begin
    if (reset || frameClear) recPtr <= hostEmuPkg::HeaderWords;
    else if (ptrAdvance) recPtr <= recPtr + recordLength;
  end

  // per-beat decision, same cycle as the beat
  always_comb begin
    beatOp = hostEmuPkg::opSkip;
    if (beatValid && !inLast) begin
      if (inHeader) begin
        beatOp = hostEmuPkg::opKeep;
      end else if (recOffset[hostEmuPkg::CountWidth-1:3] == '0) begin
        case (recOffset[2:0])
          3'd0, 3'd1: beatOp = hostEmuPkg::opKeep;   // sequence words
          3'd2, 3'd3: beatOp = hostEmuPkg::opZero;
          3'd4:       beatOp = hostEmuPkg::opDelay;
          default:    beatOp = hostEmuPkg::opSkip;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* source/frameBuffer.sv */
/*
  execute stage: stores the reduced frame, one word per cycle
  a frame must store at least one word and no more than BufferDepth
  the buffer is not written again until the sender has finished
*/
`timescale 1ns/100ps
`default_nettype none

module frameBuffer (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [hostEmuPkg::DataWidth-1:0]  inData,
  input  logic                              inValid,
  input  logic                              inLast,
  input  hostEmuPkg::storeOp                beatOp,
  input  logic [hostEmuPkg::CountWidth-1:0] readIndex,
  output logic [hostEmuPkg::DataWidth-1:0]  readData,
  output logic [hostEmuPkg::CountWidth-1:0] lastIndex,
  output logic                              frameReady
);

  logic [hostEmuPkg::DataWidth-1:0]  mem [hostEmuPkg::BufferDepth];
  logic [hostEmuPkg::CountWidth-1:0] writeCount;
  logic [hostEmuPkg::DataWidth-1:0]  writeData;
  logic                              writeEn;
  logic                              frameEnd;

  assign frameEnd = inValid && inLast;
  assign writeEn  = beatOp != hostEmuPkg::opSkip;

  ////////////////////
  // write side
  ////////////////////
  always_comb begin
    case (beatOp)
      hostEmuPkg::opZero:  writeData = '0;
      hostEmuPkg::opDelay: writeData = hostEmuPkg::InterPacketDelay;
      default:             writeData = inData;   // header and sequence words
    endcase
  end

  always_ff @(posedge clk) begin
    if (writeEn) mem[writeCount[hostEmuPkg::BufferAddrWidth-1:0]] <= writeData;
  end

  always_ff @(posedge clk) begin
    if (reset || frameEnd) writeCount <= '0;
    else if (writeEn) writeCount <= writeCount + 1'b1;
  end

  // trailer beat is never written, so the count already excludes it
  always_ff @(posedge clk) begin
    if (frameEnd) lastIndex <= writeCount - 1'b1;
  end

  always_ff @(posedge clk) begin
    if (reset) frameReady <= 1'b0;
    else frameReady <= frameEnd;   // one cycle pulse
  end

  ////////////////////
  // read side
  ////////////////////
  assign readData = mem[readIndex[hostEmuPkg::BufferAddrWidth-1:0]];

endmodule

`default_nettype wire

/* source/frameSender.sv */
/*
  result stage: replays the stored frame on the output stream
  outValid never waits on outReady, data and last hold while stalled
  a dropped frame still steps through the buffer, gated by outReady
*/
`timescale 1ns/100ps
`default_nettype none

module frameSender (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              frameReady,
  input  logic [hostEmuPkg::CountWidth-1:0] lastIndex,
  input  logic [hostEmuPkg::DataWidth-1:0]  readData,
  output logic [hostEmuPkg::CountWidth-1:0] readIndex,
  output logic [hostEmuPkg::DataWidth-1:0]  outData,
  output logic                              outValid,
  output logic                              outLast,
  input  logic                              outReady
);

  hostEmuPkg::sendState state;
  hostEmuPkg::sendState nextState;

  logic [hostEmuPkg::CountWidth-1:0] txCount;    // word being offered
  logic [hostEmuPkg::CountWidth-1:0] lossCount;  // frames since last drop
  logic                              sending;
  logic                              beatTaken;
  logic                              atLast;
  logic                              dropFrame;

  assign sending   = (state == hostEmuPkg::sendTrans) || (state == hostEmuPkg::sendWait);
  assign beatTaken = sending && outReady;
  assign atLast    = txCount == lastIndex;
  assign dropFrame = lossCount == hostEmuPkg::LossInterval;

  ////////////////////
  // send FSM
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) state <= hostEmuPkg::sendReady;
    else state <= nextState;
  end

  always_comb begin
    nextState = state;
    case (state)
      hostEmuPkg::sendReady: begin
        if (frameReady) nextState = hostEmuPkg::sendTrans;
      end
      hostEmuPkg::sendTrans, hostEmuPkg::sendWait: begin
        if (beatTaken && atLast) nextState = hostEmuPkg::sendFinished;
        else if (beatTaken) nextState = hostEmuPkg::sendTrans;
        else nextState = hostEmuPkg::sendWait;   // sink stalled, hold the beat
      end
      hostEmuPkg::sendFinished: nextState = hostEmuPkg::sendReady;
      default: nextState = hostEmuPkg::sendReady;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset || state == hostEmuPkg::sendReady) txCount <= '0;
    else if (beatTaken) txCount <= txCount + 1'b1;
  end

  // loss schedule, counted at the end of every frame
  always_ff @(posedge clk) begin
    if (reset) begin
      lossCount <= '0;
    end else if (state == hostEmuPkg::sendFinished) begin
      if (dropFrame) lossCount <= '0;
      else lossCount <= lossCount + 1'b1;
    end
  end

  ////////////////////
  // output stream
  ////////////////////
  assign readIndex = txCount;
  assign outData   = readData;
  assign outValid  = sending && !dropFrame;
  assign outLast   = outValid && atLast;

endmodule

`default_nettype wire

/* source/hostEmu.sv */
/*
  host emulator top: parse, store, send back
  input has no ready, every valid beat is taken
  next input frame may start only after the output frame is done
*/
`timescale 1ns/100ps
`default_nettype none

module hostEmu (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [hostEmuPkg::DataWidth-1:0] inData,
  input  logic                             inValid,
  input  logic                             inLast,
  output logic [hostEmuPkg::DataWidth-1:0] outData,
  output logic                             outValid,
  output logic                             outLast,
  input  logic                             outReady
);

  hostEmuPkg::storeOp                beatOp;
  logic [hostEmuPkg::CountWidth-1:0] readIndex;
  logic [hostEmuPkg::DataWidth-1:0]  readData;
  logic [hostEmuPkg::CountWidth-1:0] lastIndex;
  logic                              frameReady;

  recordParser parser (
    .clk, .reset,
    .inData, .inValid, .inLast,
    .beatOp
  );

  frameBuffer buffer (
    .clk, .reset,
    .inData, .inValid, .inLast,
    .beatOp,
    .readIndex, .readData,
    .lastIndex,
    .frameReady
  );

  // first beat goes out two cycles after inLast
  frameSender sender (
    .clk, .reset,
    .frameReady, .lastIndex,
    .readData, .readIndex,
    .outData, .outValid, .outLast,
    .outReady
  );

endmodule

`default_nettype wire

/* tests/hostEmuTb.sv */
/*
  testbench for the host emulator
  frames and expected words come from the data file
  run from the project root so the data file path resolves
  outReady is random, except while a dropped frame drains, where it is held high
*/
`timescale 1ns/100ps
`default_nettype none

module hostEmuTb;

  localparam string DataFile   = "tests/hostEmu_testdata.txt";
  localparam int    LossPeriod = int'(hostEmuPkg::LossInterval) + 1;

  logic                             clk;
  logic                             reset;
  logic [hostEmuPkg::DataWidth-1:0] inData;
  logic                             inValid;
  logic                             inLast;
  logic [hostEmuPkg::DataWidth-1:0] outData;
  logic                             outValid;
  logic                             outLast;
  logic                             outReady;

  // data file contents as flat lists with per-frame offsets
  logic [31:0] inWords[$];
  logic [31:0] expWords[$];
  int          inBase[$];
  int          inLen[$];
  int          expBase[$];
  int          expLen[$];
  int          totalBeats;
  bit          fileLoaded;
  bit          loadFailed;

  int          errorCount;
  int          framesFailed;
  int          curFrame;
  int          curStart;
  int          curLen;
  int          wordIdx;
  bit          windowOpen;   // an output frame is due
  bit          frameDone;
  bit          holdReady;
  logic [31:0] rngState;

  hostEmu UUT (
    .clk, .reset,
    .inData, .inValid, .inLast,
    .outData, .outValid, .outLast,
    .outReady
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////
  // sink side
  ////////////////////
  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  always @(posedge clk) begin
    rngState = lcgNext(rngState);
    outReady <= holdReady || rngState[16];   // low LCG bits cycle too quickly
  end

  task automatic checkBeat();
    logic [31:0] expected;
    logic        expectLast;
    expected   = expWords[curStart + wordIdx];
    expectLast = wordIdx == curLen - 1;
    assert (outData === expected) else begin
      $display("FAIL outData frame %0d word %0d: expected %h, got %h",
               curFrame, wordIdx, expected, outData);
      errorCount++;
    end
    assert (outLast === expectLast) else begin
      $display("FAIL outLast frame %0d word %0d: expected %h, got %h",
               curFrame, wordIdx, expectLast, outLast);
      errorCount++;
    end
    wordIdx++;
    if (outLast || wordIdx == curLen) begin
      assert (wordIdx == curLen) else begin
        $display("error: frame %0d output ended after %0d of %0d words",
                 curFrame, wordIdx, curLen);
        errorCount++;
      end
      windowOpen = 1'b0;
      frameDone  = 1'b1;
    end
  endtask

  // sampled mid-cycle before the transfer edge
  always @(negedge clk) begin
    if (!reset && outValid) begin
      assert (windowOpen) else begin
        $display("error: outValid high during frame %0d with no output frame due", curFrame);
        errorCount++;
      end
      if (windowOpen && outReady) checkBeat();
    end
  end

  ////////////////////
  // data file
  ////////////////////
  task automatic loadData();
    int          fd;
    int          code;
    int          nIn;
    int          nExp;
    int          pendingIn;
    int          pendingExp;
    string       tok;
    logic [31:0] word;
    pendingIn  = 0;
    pendingExp = 0;
    fd = $fopen(DataFile, "r");
    if (fd == 0) begin
      $display("error: cannot open %s", DataFile);
      loadFailed = 1'b1;
      return;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) break;
      if (tok[0] == "#") begin
        code = $fgets(tok, fd);   // drop rest of the comment line
      end else if (tok == "frame") begin
        code = $fscanf(fd, "%d %d", nIn, nExp);
        if (code != 2 || pendingIn != 0 || pendingExp != 0) loadFailed = 1'b1;
        inBase.push_back(inWords.size());
        expBase.push_back(expWords.size());
        inLen.push_back(nIn);
        expLen.push_back(nExp);
        pendingIn  = nIn;
        pendingExp = nExp;
      end else begin
        code = $sscanf(tok, "%h", word);
        if (code != 1) loadFailed = 1'b1;
        if (pendingIn > 0) begin
          inWords.push_back(word);
          pendingIn--;
        end else if (pendingExp > 0) begin
          expWords.push_back(word);
          pendingExp--;
        end else begin
          loadFailed = 1'b1;   // word outside any frame
        end
      end
    end
    $fclose(fd);
    if (pendingIn != 0 || pendingExp != 0 || inLen.size() == 0) loadFailed = 1'b1;
    if (loadFailed) $display("error: %s is malformed", DataFile);
    totalBeats = inWords.size();
    fileLoaded = !loadFailed;
  endtask

  ////////////////////
  // stimulus
  ////////////////////
  task automatic sendFrame(input int f, input bit expectOutput);
    int idx;
    for (idx = 0; idx < inLen[f]; idx++) begin
      @(posedge clk);
      inData  <= inWords[inBase[f] + idx];
      inValid <= 1'b1;
      inLast  <= idx == inLen[f] - 1;
      if (idx == inLen[f] - 1) windowOpen = expectOutput;
    end
    @(posedge clk);
    inData  <= '0;
    inValid <= 1'b0;
    inLast  <= 1'b0;
  endtask

  task automatic runFrame(input int f);
    int errorsBefore;
    bit dropped;
    errorsBefore = errorCount;
    dropped      = (f % LossPeriod) == LossPeriod - 1;
    curFrame     = f;
    curStart     = expBase[f];
    curLen       = expLen[f];
    wordIdx      = 0;
    frameDone    = 1'b0;
    holdReady    = dropped;   // lets the dropped frame drain at one word per cycle
    sendFrame(f, !dropped);
    if (dropped) begin
      repeat (expLen[f] + 10) @(posedge clk);
      holdReady = 1'b0;
    end else begin
      while (!frameDone) @(posedge clk);
      repeat (2) @(posedge clk);   // sender back to idle
    end
    if (errorCount == errorsBefore) begin
      $display("frame %0d %s: ok", f, dropped ? "dropped" : "returned");
    end else begin
      $display("frame %0d %s: %0d errors", f, dropped ? "dropped" : "returned",
               errorCount - errorsBefore);
      framesFailed++;
    end
  endtask

  // watchdog scaled to the input beat count of the file
  initial begin
    wait (fileLoaded);
    repeat (40 * totalBeats) @(posedge clk);
    $display("timeout: frames did not finish within %0d cycles", 40 * totalBeats);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    rngState   = 32'd22;
    reset      = 1'b1;
    inData     = '0;
    inValid    = 1'b0;
    inLast     = 1'b0;
    outReady   = 1'b0;
    holdReady  = 1'b0;
    windowOpen = 1'b0;
    loadData();
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    if (!loadFailed) begin
      for (int f = 0; f < inLen.size(); f++) runFrame(f);
    end
    $display("summary: %0d frames, %0d frames with errors, %0d errors",
             inLen.size(), framesFailed, errorCount);
    if (!loadFailed && errorCount == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hostEmu.f */
source/hostEmuPkg.sv
source/recordParser.sv
source/frameBuffer.sv
source/frameSender.sv
source/hostEmu.sv
tests/hostEmuTb.sv

/* run.sh */
#!/bin/sh
# builds and runs the hostEmu testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module hostEmuTb -Mdir obj_dir -f hostEmu.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/VhostEmuTb)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q '^>>> PASS$'; then
  exit 0
fi
exit 1

/* tests/hostEmu_testdata.txt */
# frame <input beats> <expected words>, then the input beats, then the expected output words
# words in hex, the last input beat is the trailer, '#' starts a comment

# frame 0: one minimal record
frame 17 9
C0000000 C0010000 C0020000 C0030000 C0040000 C0050000 C0060000 C0070000
C0080000 C0090000 C00A0000 C00B0000 C00C0000 C00D0000 C00E0000 C00F0000
C0100000
C0000000 C0010000 C0020000 C0030000 C0040000 C0050000 00000000 00000000
00000001

# frame 1: csr count 5 at beat 13, next record at 29
frame 42 14
C1000000 C1010000 C1020000 C1030000 C1040000 C1050000 C1060000 C1070000
C1080000 C1090000 C10A0000 C10B0000 C10C0000 C10D0005 C10E0000 C10F0000
C1100000 C1110000 C1120000 C1130000 C1140000 C1150000 C1160000 C1170000
C1180000 C1190000 C11A0000 C11B0000 C11C0000 C11D0000 C11E0000 C11F0000
C1200000 C1210000 C1220000 C1230000 C1240000 C1250000 C1260000 C1270000
C1280000 C1290000
C1000000 C1010000 C1020000 C1030000 C1040000 C1050000 00000000 00000000
00000001 C11D0000 C11E0000 00000000 00000000 00000001

# frame 2: gpr record (14), csr and fpr record at 18 (27), minimal record at 45
frame 58 19
C2000000 C2010000 C2020000 C2030000 C2040000 C2050000 C2060000 C2070000
C2080000 C2090000 C20A0000 C20B0000 C20C0000 C20D0000 C20E0100 C20F0000
C2100000 C2110000 C2120000 C2130000 C2140000 C2150000 C2160000 C2170000
C2180000 C2190000 C21A0000 C21B0002 C21C0001 C21D0000 C21E0000 C21F0000
C2200000 C2210000 C2220000 C2230000 C2240000 C2250000 C2260000 C2270000
C2280000 C2290000 C22A0000 C22B0000 C22C0000 C22D0000 C22E0000 C22F0000
C2300000 C2310000 C2320000 C2330000 C2340000 C2350000 C2360000 C2370000
C2380000 C2390000
C2000000 C2010000 C2020000 C2030000 C2040000 C2050000 00000000 00000000
00000001 C2120000 C2130000 00000000 00000000 00000001 C22D0000 C22E0000
00000000 00000000 00000001

# frame 3: dropped by the loss schedule
frame 17 9
C3000000 C3010000 C3020000 C3030000 C3040000 C3050000 C3060000 C3070000
C3080000 C3090000 C30A0000 C30B0000 C30C0000 C30D0000 C30E0000 C30F0000
C3100000
C3000000 C3010000 C3020000 C3030000 C3040000 C3050000 00000000 00000000
00000001

# frame 4: both enables set (14), minimal record at 18
frame 31 14
C4000000 C4010000 C4020000 C4030000 C4040000 C4050000 C4060000 C4070000
C4080000 C4090000 C40A0000 C40B0000 C40C0000 C40D0000 C40E0101 C40F0000
C4100000 C4110000 C4120000 C4130000 C4140000 C4150000 C4160000 C4170000
C4180000 C4190000 C41A0000 C41B0000 C41C0000 C41D0000 C41E0000
C4000000 C4010000 C4020000 C4030000 C4040000 C4050000 00000000 00000000
00000001 C4120000 C4130000 00000000 00000000 00000001
